//--- filelist.f
hw/cnn_cfg_pkg.sv
hw/cnn_ctrl_pkg.sv
hw/fm_ram.sv
hw/weight_ram.sv
hw/fm_port_arbiter.sv
hw/layer_loader.sv
hw/conv_engine.sv
hw/conv_layer_top.sv
tests/tb_conv_layer.sv

//--- hw/cnn_cfg_pkg.sv
package cnn_cfg_pkg;

	parameter int DEF_DATA_W = 8; // signed fixed-point word
	parameter int DEF_FM_SIZE_MAX = 8; // largest map side, also the row stride
	parameter int DEF_KERNEL_SIZE = 3;

	localparam int size_w = 4; // fm_size field

	// map memory holds fm_size_max squared words
	function automatic int fm_addr_w(input int fm_size_max);
		return $clog2(fm_size_max * fm_size_max);
	endfunction

	function automatic int w_addr_w(input int kernel_size);
		return $clog2(kernel_size * kernel_size);
	endfunction

	// full product plus headroom for the window sum
	function automatic int acc_w(input int data_w);
		return 2 * data_w + 4;
	endfunction

endpackage

//--- hw/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

	// host operation select
	typedef enum logic [1:0] {
		op_idle = 2'd0,
		op_load = 2'd1,
		op_conv = 2'd2
	} layer_op_e;

	typedef enum logic [1:0] {
		st_idle = 2'd0, // waiting for op_conv and both memories ready
		st_read = 2'd1, // walking the window, one granted read per tap
		st_emit = 2'd2, // last product lands, step the window origin
		st_done = 2'd3  // layer finished, hold until op_conv is dropped
	} conv_state_e;

	// owner of the feature-map memory port
	typedef enum logic {
		gnt_loader = 1'b0,
		gnt_engine = 1'b1
	} grant_e;

endpackage

//--- hw/conv_engine.sv
`timescale 1ns/1ns

module conv_engine #(
	parameter int DATA_W = cnn_cfg_pkg::DEF_DATA_W,
	parameter int FM_SIZE_MAX = cnn_cfg_pkg::DEF_FM_SIZE_MAX,
	parameter int KERNEL_SIZE = cnn_cfg_pkg::DEF_KERNEL_SIZE
) (
	input logic clk,
	input logic rst,
	input cnn_ctrl_pkg::layer_op_e layer_op_i,
	input logic [cnn_cfg_pkg::size_w-1:0] fm_size_i,
	input logic fm_ready_i,
	input logic weight_ready_i,
	output logic eng_req_o,
	output logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] eng_addr_o,
	input logic eng_gnt_i,
	input logic [DATA_W-1:0] fm_rdata_i,
	output logic [cnn_cfg_pkg::w_addr_w(KERNEL_SIZE)-1:0] w_raddr_o,
	input logic [DATA_W-1:0] w_rdata_i,
	output logic result_valid_o,
	output logic signed [cnn_cfg_pkg::acc_w(DATA_W)-1:0] result_o,
	output logic layer_done_o
);

	import cnn_cfg_pkg::*;
	import cnn_ctrl_pkg::*;

	localparam int FM_AW = fm_addr_w(FM_SIZE_MAX);
	localparam int W_AW = w_addr_w(KERNEL_SIZE);
	localparam int ACC_W = acc_w(DATA_W);
	localparam int PROD_W = 2 * DATA_W;
	localparam logic [size_w-1:0] K_LAST = size_w'(KERNEL_SIZE - 1);

	conv_state_e state;

	logic [size_w-1:0] org_r, org_c; // window origin
	logic [size_w-1:0] kr, kc; // tap inside the window
	logic [size_w-1:0] org_last;
	logic [size_w-1:0] row, col;
	logic start;
	logic rd_vld; // data of last cycle's granted read sits on the ram outputs
	logic signed [PROD_W-1:0] prod;
	logic signed [ACC_W-1:0] acc;

	assign org_last = fm_size_i - size_w'(KERNEL_SIZE); // last valid origin
	assign start = (layer_op_i == op_conv) && fm_ready_i && weight_ready_i;

	// row stride is fixed at FM_SIZE_MAX whatever fm_size is
	assign row = org_r + kr;
	assign col = org_c + kc;
	assign eng_addr_o = FM_AW'(row * FM_SIZE_MAX + col);
	assign w_raddr_o = W_AW'(kr * KERNEL_SIZE + kc);
	assign eng_req_o = (state == st_read);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			org_r <= '0;
			org_c <= '0;
			kr <= '0;
			kc <= '0;
			rd_vld <= 1'b0;
			result_valid_o <= 1'b0;
			layer_done_o <= 1'b0;
		end else begin
			rd_vld <= eng_req_o && eng_gnt_i;
			result_valid_o <= (state == st_emit); // acc is complete one cycle after emit
			layer_done_o <= (state == st_done) && result_valid_o; // right after the last result

			case (state)
				st_idle: begin
					if (start) state <= st_read;
				end
				st_read: begin
					// no grant means hold everything
					if (eng_gnt_i) begin
						if (kc == K_LAST) begin
							kc <= '0;
							if (kr == K_LAST) begin
								kr <= '0;
								state <= st_emit;
							end else begin
								kr <= kr + 1'b1;
							end
						end else begin
							kc <= kc + 1'b1;
						end
					end
				end
				st_emit: begin
					// raster step of the origin
					if (org_c == org_last) begin
						org_c <= '0;
						if (org_r == org_last) begin
							org_r <= '0;
							state <= st_done;
						end else begin
							org_r <= org_r + 1'b1;
							state <= st_read;
						end
					end else begin
						org_c <= org_c + 1'b1;
						state <= st_read;
					end
				end
				st_done: begin
					if (layer_op_i != op_conv) state <= st_idle; // needs a fresh op_conv
				end
			endcase
		end
	end

	assign prod = $signed(fm_rdata_i) * $signed(w_rdata_i);

	always_ff @(posedge clk) begin
		if (state == st_idle || result_valid_o) begin
			acc <= '0; // result shown this cycle so the next window starts clean
		end else if (rd_vld) begin
			acc <= acc + {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
		end
	end

	assign result_o = acc;

	a_valid_done_excl: assert property (@(posedge clk) disable iff (!rst)
		!(result_valid_o && layer_done_o));

endmodule

//--- hw/conv_layer_top.sv
`timescale 1ns/1ns

module conv_layer_top #(
	parameter int DATA_W = cnn_cfg_pkg::DEF_DATA_W,
	parameter int FM_SIZE_MAX = cnn_cfg_pkg::DEF_FM_SIZE_MAX,
	parameter int KERNEL_SIZE = cnn_cfg_pkg::DEF_KERNEL_SIZE
) (
	input logic clk,
	input logic rst,
	input cnn_ctrl_pkg::layer_op_e layer_op_i,
	input logic [cnn_cfg_pkg::size_w-1:0] fm_size_i,
	input logic fm_wr_en_i,
	input logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] fm_wr_addr_i,
	input logic [DATA_W-1:0] fm_wr_data_i,
	input logic w_wr_en_i,
	input logic [cnn_cfg_pkg::w_addr_w(KERNEL_SIZE)-1:0] w_wr_addr_i,
	input logic [DATA_W-1:0] w_wr_data_i,
	input logic fm_load_done_i,
	input logic w_load_done_i,
	output logic fm_ready_o,
	output logic weight_ready_o,
	output logic result_valid_o,
	output logic signed [cnn_cfg_pkg::acc_w(DATA_W)-1:0] result_o,
	output logic layer_done_o
);

	import cnn_cfg_pkg::*;

	localparam int FM_AW = fm_addr_w(FM_SIZE_MAX);
	localparam int W_AW = w_addr_w(KERNEL_SIZE);

	logic ld_req, eng_req, eng_gnt;
	logic [FM_AW-1:0] ld_addr, eng_addr, mem_addr;
	logic [DATA_W-1:0] ld_data, mem_wdata, fm_rdata;
	logic mem_we;
	logic w_we;
	logic [W_AW-1:0] w_waddr, w_raddr;
	logic [DATA_W-1:0] w_wdata, w_rdata;

	layer_loader #(.DATA_W(DATA_W), .FM_SIZE_MAX(FM_SIZE_MAX), .KERNEL_SIZE(KERNEL_SIZE)) u_loader (
		.clk(clk), .rst(rst), .layer_op_i(layer_op_i),
		.fm_wr_en_i(fm_wr_en_i), .fm_wr_addr_i(fm_wr_addr_i), .fm_wr_data_i(fm_wr_data_i),
		.w_wr_en_i(w_wr_en_i), .w_wr_addr_i(w_wr_addr_i), .w_wr_data_i(w_wr_data_i),
		.fm_load_done_i(fm_load_done_i), .w_load_done_i(w_load_done_i),
		.ld_req_o(ld_req), .ld_addr_o(ld_addr), .ld_data_o(ld_data),
		.w_we_o(w_we), .w_waddr_o(w_waddr), .w_wdata_o(w_wdata),
		.fm_ready_o(fm_ready_o), .weight_ready_o(weight_ready_o)
	);

	conv_engine #(.DATA_W(DATA_W), .FM_SIZE_MAX(FM_SIZE_MAX), .KERNEL_SIZE(KERNEL_SIZE)) u_engine (
		.clk(clk), .rst(rst), .layer_op_i(layer_op_i), .fm_size_i(fm_size_i),
		.fm_ready_i(fm_ready_o), .weight_ready_i(weight_ready_o),
		.eng_req_o(eng_req), .eng_addr_o(eng_addr), .eng_gnt_i(eng_gnt), .fm_rdata_i(fm_rdata),
		.w_raddr_o(w_raddr), .w_rdata_i(w_rdata),
		.result_valid_o(result_valid_o), .result_o(result_o), .layer_done_o(layer_done_o)
	);

	// loader and engine share the one map port
	fm_port_arbiter #(.DATA_W(DATA_W), .FM_SIZE_MAX(FM_SIZE_MAX)) u_arb (
		.clk(clk), .ld_req_i(ld_req), .ld_addr_i(ld_addr), .ld_data_i(ld_data),
		.eng_req_i(eng_req), .eng_addr_i(eng_addr), .eng_gnt_o(eng_gnt),
		.mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
	);

	fm_ram #(.DATA_W(DATA_W), .FM_SIZE_MAX(FM_SIZE_MAX)) u_fm_ram (
		.clk(clk), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata), .rdata_o(fm_rdata)
	);

	weight_ram #(.DATA_W(DATA_W), .KERNEL_SIZE(KERNEL_SIZE)) u_weight_ram (
		.clk(clk), .we_i(w_we), .waddr_i(w_waddr), .wdata_i(w_wdata),
		.raddr_i(w_raddr), .rdata_o(w_rdata)
	);

endmodule

//--- hw/fm_port_arbiter.sv
`timescale 1ns/1ns

module fm_port_arbiter #(
	parameter int DATA_W = cnn_cfg_pkg::DEF_DATA_W,
	parameter int FM_SIZE_MAX = cnn_cfg_pkg::DEF_FM_SIZE_MAX
) (
	input logic clk, // sampling only
	input logic ld_req_i,
	input logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] ld_addr_i,
	input logic [DATA_W-1:0] ld_data_i,
	input logic eng_req_i,
	input logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] eng_addr_i,
	output logic eng_gnt_o,
	output logic mem_we_o,
	output logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] mem_addr_o,
	output logic [DATA_W-1:0] mem_wdata_o
);

	import cnn_ctrl_pkg::*;

	grant_e owner;

	// loader always first, engine gets whatever is left
	always_comb begin
		owner = ld_req_i ? gnt_loader : gnt_engine;
	end

	assign eng_gnt_o = (owner == gnt_engine) && eng_req_i;
	assign mem_we_o = (owner == gnt_loader) && ld_req_i;

	always_comb begin
		if (owner == gnt_loader) begin
			mem_addr_o = ld_addr_i;
		end else begin
			mem_addr_o = eng_addr_i; // idle cycles just read at the engine address
		end
	end

	assign mem_wdata_o = ld_data_i; // only looked at on a write

	a_no_eng_write: assert property (@(posedge clk) !(mem_we_o && owner == gnt_engine));
	a_ld_first: assert property (@(posedge clk) !(eng_gnt_o && ld_req_i));

endmodule

//--- hw/fm_ram.sv
`timescale 1ns/1ns

module fm_ram #(
	parameter int DATA_W = cnn_cfg_pkg::DEF_DATA_W,
	parameter int FM_SIZE_MAX = cnn_cfg_pkg::DEF_FM_SIZE_MAX
) (
	input logic clk,
	input logic we_i,
	input logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] addr_i,
	input logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] rdata_o
);

	localparam int DEPTH = FM_SIZE_MAX * FM_SIZE_MAX;

	// word at row * FM_SIZE_MAX + column
	logic [DATA_W-1:0] mem [DEPTH];

	// single port, a write blocks the read for that cycle
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end else begin
			rdata_o <= mem[addr_i]; // data one cycle after the address
		end
	end

endmodule

//--- hw/layer_loader.sv
`timescale 1ns/1ns

module layer_loader #(
	parameter int DATA_W = cnn_cfg_pkg::DEF_DATA_W,
	parameter int FM_SIZE_MAX = cnn_cfg_pkg::DEF_FM_SIZE_MAX,
	parameter int KERNEL_SIZE = cnn_cfg_pkg::DEF_KERNEL_SIZE
) (
	input logic clk,
	input logic rst,
	input cnn_ctrl_pkg::layer_op_e layer_op_i,
	input logic fm_wr_en_i,
	input logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] fm_wr_addr_i,
	input logic [DATA_W-1:0] fm_wr_data_i,
	input logic w_wr_en_i,
	input logic [cnn_cfg_pkg::w_addr_w(KERNEL_SIZE)-1:0] w_wr_addr_i,
	input logic [DATA_W-1:0] w_wr_data_i,
	input logic fm_load_done_i,
	input logic w_load_done_i,
	output logic ld_req_o,
	output logic [cnn_cfg_pkg::fm_addr_w(FM_SIZE_MAX)-1:0] ld_addr_o,
	output logic [DATA_W-1:0] ld_data_o,
	output logic w_we_o,
	output logic [cnn_cfg_pkg::w_addr_w(KERNEL_SIZE)-1:0] w_waddr_o,
	output logic [DATA_W-1:0] w_wdata_o,
	output logic fm_ready_o,
	output logic weight_ready_o
);

	import cnn_ctrl_pkg::*;

	logic loading;

	assign loading = (layer_op_i == op_load); // host writes outside a load are dropped

	assign ld_req_o = loading && fm_wr_en_i;
	assign ld_addr_o = fm_wr_addr_i;
	assign ld_data_o = fm_wr_data_i;

	assign w_we_o = loading && w_wr_en_i;
	assign w_waddr_o = w_wr_addr_i;
	assign w_wdata_o = w_wr_data_i;

	// done pulse wins over a write in the same cycle
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fm_ready_o <= 1'b0;
			weight_ready_o <= 1'b0;
		end else begin
			if (fm_load_done_i) fm_ready_o <= 1'b1;
			else if (ld_req_o) fm_ready_o <= 1'b0; // map being rewritten

			if (w_load_done_i) weight_ready_o <= 1'b1;
			else if (w_we_o) weight_ready_o <= 1'b0;
		end
	end

endmodule

//--- hw/weight_ram.sv
`timescale 1ns/1ns

module weight_ram #(
	parameter int DATA_W = cnn_cfg_pkg::DEF_DATA_W,
	parameter int KERNEL_SIZE = cnn_cfg_pkg::DEF_KERNEL_SIZE
) (
	input logic clk,
	input logic we_i,
	input logic [cnn_cfg_pkg::w_addr_w(KERNEL_SIZE)-1:0] waddr_i,
	input logic [DATA_W-1:0] wdata_i,
	input logic [cnn_cfg_pkg::w_addr_w(KERNEL_SIZE)-1:0] raddr_i,
	output logic [DATA_W-1:0] rdata_o
);

	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

	logic [DATA_W-1:0] regs [TAPS]; // row * KERNEL_SIZE + column

	always_ff @(posedge clk) begin
		if (we_i) regs[waddr_i] <= wdata_i;
		rdata_o <= regs[raddr_i]; // lines up with the map word from fm_ram
	end

	// host addressing has to stay inside the kernel
	a_waddr_range: assert property (@(posedge clk) we_i |-> (int'(waddr_i) < TAPS));

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_conv_layer -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_conv_layer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

//--- tests/tb_conv_layer.sv
`timescale 1ns/1ns

module tb_conv_layer;

	import cnn_ctrl_pkg::*;

	localparam int DATA_W = 8;
	localparam int FM_SIZE_MAX = 8;
	localparam int KERNEL_SIZE = 3;
	localparam int FM_DEPTH = FM_SIZE_MAX * FM_SIZE_MAX;
	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;
	localparam int LAYER_TIMEOUT = 2000; // a full 8x8 layer needs about 400 cycles
	localparam logic [DATA_W-1:0] MOST_NEG = {1'b1, {(DATA_W - 1){1'b0}}};

	logic clk, rst;
	layer_op_e layer_op;
	logic [3:0] fm_size;
	logic fm_wr_en, w_wr_en, fm_load_done, w_load_done;
	logic [5:0] fm_wr_addr;
	logic [3:0] w_wr_addr;
	logic [DATA_W-1:0] fm_wr_data, w_wr_data;
	logic fm_ready, weight_ready, result_valid, layer_done;
	logic signed [2*DATA_W+3:0] result;

	int fm_model [FM_DEPTH]; // shadow of the map memory
	int w_model [TAPS];
	int error_count, errors_at_start, tests_passed, tests_failed;

	conv_layer_top #(
		.DATA_W(DATA_W), .FM_SIZE_MAX(FM_SIZE_MAX), .KERNEL_SIZE(KERNEL_SIZE)
	) UUT (
		.clk(clk), .rst(rst), .layer_op_i(layer_op), .fm_size_i(fm_size),
		.fm_wr_en_i(fm_wr_en), .fm_wr_addr_i(fm_wr_addr), .fm_wr_data_i(fm_wr_data),
		.w_wr_en_i(w_wr_en), .w_wr_addr_i(w_wr_addr), .w_wr_data_i(w_wr_data),
		.fm_load_done_i(fm_load_done), .w_load_done_i(w_load_done),
		.fm_ready_o(fm_ready), .weight_ready_o(weight_ready),
		.result_valid_o(result_valid), .result_o(result), .layer_done_o(layer_done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic end_test(input string name);
		if (error_count == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	task automatic set_op(input layer_op_e op);
		@(posedge clk);
		layer_op <= op;
	endtask

	// signed sum of products for the window at (org_r, org_c)
	function automatic int window_sum(input int org_r, input int org_c);
		int sum;
		sum = 0;
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				sum += fm_model[(org_r + r) * FM_SIZE_MAX + org_c + c]
					* w_model[r * KERNEL_SIZE + c];
			end
		end
		return sum;
	endfunction

	task automatic load_map(input bit extreme);
		logic [DATA_W-1:0] word;
		for (int a = 0; a < FM_DEPTH; a++) begin
			word = extreme ? MOST_NEG : DATA_W'($urandom);
			fm_model[a] = $signed(word);
			@(posedge clk);
			fm_wr_en <= 1'b1;
			fm_wr_addr <= 6'(a);
			fm_wr_data <= word;
		end
		@(posedge clk);
		fm_wr_en <= 1'b0;
	endtask

	task automatic load_kernel(input bit extreme);
		logic [DATA_W-1:0] word;
		for (int a = 0; a < TAPS; a++) begin
			word = extreme ? MOST_NEG : DATA_W'($urandom);
			w_model[a] = $signed(word);
			@(posedge clk);
			w_wr_en <= 1'b1;
			w_wr_addr <= 4'(a);
			w_wr_data <= word;
		end
		@(posedge clk);
		w_wr_en <= 1'b0;
	endtask

	task automatic pulse_done(input bit weights);
		@(posedge clk);
		if (weights) w_load_done <= 1'b1;
		else fm_load_done <= 1'b1;
		@(posedge clk);
		fm_load_done <= 1'b0;
		w_load_done <= 1'b0;
	endtask

	// nothing may come out during a fixed window
	task automatic hold_quiet(input string name, input int cycles);
		int valids, dones;
		valids = 0;
		dones = 0;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (result_valid) valids++;
			if (layer_done) dones++;
		end
		check_value({name, " quiet results"}, 0, valids);
		check_value({name, " quiet layer_done"}, 0, dones);
	endtask

	task automatic run_conv(input string name, input int size);
		int side, n_res, waited;
		bit done_seen;
		side = size - KERNEL_SIZE + 1;
		n_res = 0;
		waited = 0;
		done_seen = 1'b0;
		@(posedge clk);
		fm_size <= 4'(size);
		layer_op <= op_conv;
		while (!done_seen && waited < LAYER_TIMEOUT) begin
			@(negedge clk);
			waited++;
			if (result_valid) begin
				if (n_res < side * side) begin
					check_value($sformatf("%s result %0d", name, n_res),
						window_sum(n_res / side, n_res % side), result);
				end else begin
					$display("%s: result_valid_o seen after the last window", name);
					error_count++;
				end
				n_res++;
			end
			if (layer_done) done_seen = 1'b1;
		end
		if (!done_seen) begin
			$display("Timeout in %s: layer_done_o not seen after %0d cycles", name, waited);
			error_count++;
		end
		check_value({name, " result count"}, side * side, n_res);
		hold_quiet(name, 10); // layer_done_o is a single pulse
	endtask

	initial begin
		void'($urandom(49));
		rst = 1'b0;
		layer_op = op_idle;
		fm_size = 4'd8;
		fm_wr_en = 1'b0;
		fm_wr_addr = '0;
		fm_wr_data = '0;
		w_wr_en = 1'b0;
		w_wr_addr = '0;
		w_wr_data = '0;
		fm_load_done = 1'b0;
		w_load_done = 1'b0;
		error_count = 0;
		errors_at_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;

		@(negedge clk);
		check_value("reset fm_ready", 0, fm_ready);
		check_value("reset weight_ready", 0, weight_ready);
		set_op(op_conv); // nothing loaded yet
		hold_quiet("conv before load", 50);
		end_test("conv before load");

		set_op(op_load);
		load_map(1'b0);
		pulse_done(1'b0);
		load_kernel(1'b0);
		pulse_done(1'b1);
		set_op(op_idle);
		@(negedge clk);
		check_value("loaded fm_ready", 1, fm_ready);
		check_value("loaded weight_ready", 1, weight_ready);
		run_conv("full map 8", 8);
		end_test("full map 8");

		set_op(op_idle);
		run_conv("map 5", 5);
		end_test("map 5");

		hold_quiet("held op_conv", 60); // engine parked in st_done
		set_op(op_idle);
		run_conv("reselect map 5", 5);
		end_test("hold and reselect");

		set_op(op_load);
		load_kernel(1'b0);
		@(negedge clk);
		check_value("kernel write weight_ready", 0, weight_ready);
		check_value("kernel write fm_ready", 1, fm_ready);
		pulse_done(1'b1);
		@(negedge clk);
		check_value("kernel done weight_ready", 1, weight_ready);
		check_value("kernel done fm_ready", 1, fm_ready);
		set_op(op_idle);
		run_conv("new kernel", 8);
		end_test("new kernel");

		set_op(op_load);
		load_map(1'b1);
		pulse_done(1'b0);
		load_kernel(1'b1);
		pulse_done(1'b1);
		set_op(op_idle);
		run_conv("extreme values", 3);
		end_test("extreme values");

		$display("tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
